// ==== Bender.yml ====
package:
  name: fp16_add_unit

sources:
  - files:
      - hw/fp16_pkg.sv
      - hw/fp_flags_if.sv
      - hw/left_shift.sv
      - hw/fp16_align.sv
      - hw/fp16_add_round.sv
      - hw/fp_status_reg.sv
      - hw/fp16_add_unit.sv
  - target: test
    files:
      - testbench/tb_fp16_add_unit.sv

// ==== hw/fp16_add_round.sv ====
module fp16_add_round (
    input  logic                          clk,
    input  logic                          nRST,
    input  logic                          valid,
    input  logic [fp16_pkg::MANT_W-1:0]   large_mant,
    input  logic [fp16_pkg::MANT_W-1:0]   small_mant,
    input  logic [fp16_pkg::EXP_W-1:0]    exp_max,
    input  logic                          large_sign,
    input  logic                          sign_a,
    input  logic                          sign_b,
    input  logic                          signs_differ,
    input  logic                          align_sticky,
    fp_flags_if.source                    flags,
    output fp16_pkg::fp16_t               fp_out,
    output logic                          output_ready
);
    import fp16_pkg::*;

    logic [MANT_W:0]   mant_sum;
    logic              result_sign;
    logic              carry;
    logic              sum_zero;
    logic [MANT_W-1:0] norm_mant;
    logic [3:0]        norm_shift;
    logic [MANT_W-1:0] round_in;
    logic              sticky;
    logic [EXP_W:0]    exp_norm;
    logic              exp_low;
    logic              guard_bit;
    logic              round_bit;
    logic              round_up;
    logic [FRAC_W+1:0] mant_rnd;
    logic [EXP_W:0]    exp_final;
    logic [FRAC_W-1:0] frac_final;
    fp_flags_t         res_flags;

    // equal signs add magnitudes and keep the common sign
    // opposite signs subtract and take the sign of the larger magnitude
    always_comb begin
        if (!signs_differ) begin
            mant_sum    = {1'b0, large_mant} + {1'b0, small_mant};
            result_sign = sign_a & sign_b;
        end else begin
            mant_sum    = {1'b0, large_mant} - {1'b0, small_mant};
            result_sign = large_sign;
        end
    end

    assign carry    = mant_sum[MANT_W];
    assign sum_zero = (mant_sum == '0);

    left_shift u_norm (
        .fraction       (mant_sum[MANT_W-1:0]),
        .result         (norm_mant),
        .shifted_amount (norm_shift)
    );

    // a carry out needs one right shift, the bit shifted out joins the sticky bit
    // otherwise the normalizer has already moved the leading one into place
    always_comb begin
        if (carry) begin
            round_in = mant_sum[MANT_W:1];
            sticky   = align_sticky | mant_sum[0];
            exp_norm = {1'b0, exp_max} + 1'b1;
            exp_low  = 1'b0;
        end else begin
            round_in = norm_mant;
            sticky   = align_sticky;
            exp_norm = {1'b0, exp_max} - {2'b0, norm_shift};
            // the exponent would end up below one, which is outside the normal range
            exp_low  = ({1'b0, exp_max} <= {2'b0, norm_shift});
        end
    end

    // round to nearest, ties to even
    // the fraction lsb breaks the tie when guard is set and nothing below it is
    assign guard_bit = round_in[1];
    assign round_bit = round_in[0];
    assign round_up  = guard_bit & (round_bit | sticky | round_in[2]);

    // one spare bit catches the carry of an all-ones mantissa rounding up
    assign mant_rnd  = {1'b0, round_in[MANT_W-1:2]} + {{(FRAC_W+1){1'b0}}, round_up};
    assign exp_final = exp_norm + {{EXP_W{1'b0}}, mant_rnd[FRAC_W+1]};

    // after a rounding carry the mantissa is exactly 10.0, so its fraction is zero
    assign frac_final = mant_rnd[FRAC_W+1] ? mant_rnd[FRAC_W:1] : mant_rnd[FRAC_W-1:0];

    // pick the encoded result, the special cases are checked in priority order
    always_comb begin
        res_flags         = '0;
        res_flags.inexact = guard_bit | round_bit | sticky;
        fp_out.sign       = result_sign;
        fp_out.exp        = exp_final[EXP_W-1:0];
        fp_out.frac       = frac_final;
        if (sum_zero) begin
            // exact cancellation gives +0, two zeros of the same sign keep it
            fp_out            = '0;
            fp_out.sign       = result_sign & ~signs_differ;
            res_flags.inexact = 1'b0;
        end else if (exp_low) begin
            // no subnormals, so the result is flushed to a signed zero
            fp_out.exp    = '0;
            fp_out.frac   = '0;
            res_flags.unf = 1'b1;
        end else if (exp_final > EXP_MAX) begin
            fp_out.exp    = '1;
            fp_out.frac   = '0;
            res_flags.ovf = 1'b1;
        end
    end

    // the result belongs to the operands captured one cycle earlier
    assign output_ready = valid;

    // flags are only raised alongside a fresh result
    assign flags.valid   = valid;
    assign flags.ovf     = valid & res_flags.ovf;
    assign flags.unf     = valid & res_flags.unf;
    assign flags.inexact = valid & res_flags.inexact;

    // finite operands can only reach the infinity encoding through overflow
    a_inf_needs_ovf: assert property (@(posedge clk) disable iff (!nRST)
        (output_ready && fp_out.exp == '1) |-> flags.ovf);

endmodule

// ==== hw/fp16_add_unit.sv ====
module fp16_add_unit (
    input  logic            clk,
    input  logic            nRST,
    input  logic            start,
    input  fp16_pkg::fp16_t fp1_in,
    input  fp16_pkg::fp16_t fp2_in,
    input  logic            flags_clear,
    output fp16_pkg::fp16_t fp_out,
    output logic            output_ready,
    output logic            ovf,
    output logic            unf,
    output logic            inexact,
    output logic            sticky_ovf,
    output logic            sticky_unf,
    output logic            sticky_inexact
);
    import fp16_pkg::*;

    // pipeline register fields between the align and add stages
    logic              stage_valid;
    logic [MANT_W-1:0] large_mant;
    logic [MANT_W-1:0] small_mant;
    logic [EXP_W-1:0]  exp_max;
    logic              large_sign;
    logic              sign_a;
    logic              sign_b;
    logic              signs_differ;
    logic              align_sticky;

    fp_flags_if flags_bus ();

    // stage one aligns the operands and holds them in the pipeline register
    fp16_align u_align (
        .clk          (clk),
        .nRST         (nRST),
        .start        (start),
        .fp1_in       (fp1_in),
        .fp2_in       (fp2_in),
        .valid        (stage_valid),
        .large_mant   (large_mant),
        .small_mant   (small_mant),
        .exp_max      (exp_max),
        .large_sign   (large_sign),
        .sign_a       (sign_a),
        .sign_b       (sign_b),
        .signs_differ (signs_differ),
        .align_sticky (align_sticky)
    );

    // stage two is combinational from that register to the result
    fp16_add_round u_add_round (
        .clk          (clk),
        .nRST         (nRST),
        .valid        (stage_valid),
        .large_mant   (large_mant),
        .small_mant   (small_mant),
        .exp_max      (exp_max),
        .large_sign   (large_sign),
        .sign_a       (sign_a),
        .sign_b       (sign_b),
        .signs_differ (signs_differ),
        .align_sticky (align_sticky),
        .flags        (flags_bus.source),
        .fp_out       (fp_out),
        .output_ready (output_ready)
    );

    fp_status_reg u_status (
        .clk            (clk),
        .nRST           (nRST),
        .flags_clear    (flags_clear),
        .flags          (flags_bus.sink),
        .sticky_ovf     (sticky_ovf),
        .sticky_unf     (sticky_unf),
        .sticky_inexact (sticky_inexact)
    );

    // per-result flags are also visible at the top level
    assign ovf     = flags_bus.ovf;
    assign unf     = flags_bus.unf;
    assign inexact = flags_bus.inexact;

endmodule

// ==== hw/fp16_align.sv ====
module fp16_align (
    input  logic                          clk,
    input  logic                          nRST,
    input  logic                          start,
    input  fp16_pkg::fp16_t               fp1_in,
    input  fp16_pkg::fp16_t               fp2_in,
    output logic                          valid,
    output logic [fp16_pkg::MANT_W-1:0]   large_mant,
    output logic [fp16_pkg::MANT_W-1:0]   small_mant,
    output logic [fp16_pkg::EXP_W-1:0]    exp_max,
    output logic                          large_sign,
    output logic                          sign_a,
    output logic                          sign_b,
    output logic                          signs_differ,
    output logic                          align_sticky
);
    import fp16_pkg::*;

    logic              fp1_larger;
    logic [EXP_W-1:0]  exp_big;
    logic [EXP_W-1:0]  exp_diff;
    logic [MANT_W-1:0] mant1;
    logic [MANT_W-1:0] mant2;
    logic [MANT_W-1:0] mant_keep;
    logic [MANT_W-1:0] mant_shift_in;
    logic [MANT_W-1:0] mant_shifted;
    logic [MANT_W-1:0] lost_mask;
    logic              sign_keep;
    logic              sign_shifted;
    logic              sticky_next;
    logic [MANT_W-1:0] large_next;
    logic [MANT_W-1:0] small_next;
    logic              large_sign_next;

    // an exponent of zero means the value is zero, so it gets no hidden bit
    // two zero guard bits are appended below the fraction
    assign mant1 = {(fp1_in.exp != '0), fp1_in.frac, {(MANT_W-FRAC_W-1){1'b0}}};
    assign mant2 = {(fp2_in.exp != '0), fp2_in.frac, {(MANT_W-FRAC_W-1){1'b0}}};

    // on equal exponents fp1 is kept unshifted, the magnitude sort below fixes the order
    assign fp1_larger = (fp1_in.exp >= fp2_in.exp);

    always_comb begin
        if (fp1_larger) begin
            exp_big       = fp1_in.exp;
            exp_diff      = fp1_in.exp - fp2_in.exp;
            mant_keep     = mant1;
            sign_keep     = fp1_in.sign;
            mant_shift_in = mant2;
            sign_shifted  = fp2_in.sign;
        end else begin
            exp_big       = fp2_in.exp;
            exp_diff      = fp2_in.exp - fp1_in.exp;
            mant_keep     = mant2;
            sign_keep     = fp2_in.sign;
            mant_shift_in = mant1;
            sign_shifted  = fp1_in.sign;
        end
    end

    // the shifter only looks at the low four bits of the difference
    // a difference of 16 or more wipes the mantissa out completely
    always_comb begin
        lost_mask = ~({MANT_W{1'b1}} << exp_diff[3:0]);
        if (exp_diff[EXP_W-1]) begin
            mant_shifted = '0;
            sticky_next  = |mant_shift_in;
        end else begin
            mant_shifted = mant_shift_in >> exp_diff[3:0];
            sticky_next  = |(mant_shift_in & lost_mask);
        end
    end

    // order the aligned mantissas so that the add stage can always subtract small from large
    always_comb begin
        if (mant_shifted > mant_keep) begin
            large_next      = mant_shifted;
            small_next      = mant_keep;
            large_sign_next = sign_shifted;
        end else begin
            large_next      = mant_keep;
            small_next      = mant_shifted;
            large_sign_next = sign_keep;
        end
    end

    // the operand fields are only loaded on start so the result stays put between operations
    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            valid        <= 1'b0;
            large_mant   <= '0;
            small_mant   <= '0;
            exp_max      <= '0;
            large_sign   <= 1'b0;
            sign_a       <= 1'b0;
            sign_b       <= 1'b0;
            signs_differ <= 1'b0;
            align_sticky <= 1'b0;
        end else begin
            valid <= start;
            if (start) begin
                large_mant   <= large_next;
                small_mant   <= small_next;
                exp_max      <= exp_big;
                large_sign   <= large_sign_next;
                sign_a       <= fp1_in.sign;
                sign_b       <= fp2_in.sign;
                signs_differ <= fp1_in.sign ^ fp2_in.sign;
                align_sticky <= sticky_next;
            end
        end
    end

    // the add stage relies on this ordering to never produce a negative difference
    a_mant_ordered: assert property (@(posedge clk) disable iff (!nRST)
        large_mant >= small_mant);

endmodule

// ==== hw/fp16_pkg.sv ====
package fp16_pkg;

    // widths of the fields of an IEEE 754 half-precision word
    localparam int unsigned EXP_W  = 5;
    localparam int unsigned FRAC_W = 10;

    // the working mantissa is the hidden bit, the stored fraction and two guard bits
    // the lower guard bit acts as the round bit during rounding
    localparam int unsigned MANT_W = 13;

    // largest finite biased exponent, since the all-ones exponent encodes infinity
    localparam int unsigned EXP_MAX = 30;

    // one FP16 value with the sign in the top bit, then exponent, then fraction
    typedef struct packed {
        logic              sign;
        logic [EXP_W-1:0]  exp;
        logic [FRAC_W-1:0] frac;
    } fp16_t;

    // exception flags raised by a single add result
    typedef struct packed {
        logic ovf;
        logic unf;
        logic inexact;
    } fp_flags_t;

endpackage

// ==== hw/fp_flags_if.sv ====
// exception flags of one add result, sent from the adder to the status register
// ovf, unf and inexact only carry information in a cycle where valid is high
interface fp_flags_if;

    logic valid;
    logic ovf;
    logic unf;
    logic inexact;

    // the add stage produces the flags
    modport source (
        output valid,
        output ovf,
        output unf,
        output inexact
    );

    // the sticky status register consumes them
    modport sink (
        input valid,
        input ovf,
        input unf,
        input inexact
    );

endinterface

// ==== hw/fp_status_reg.sv ====
module fp_status_reg (
    input  logic       clk,
    input  logic       nRST,
    input  logic       flags_clear,
    fp_flags_if.sink   flags,
    output logic       sticky_ovf,
    output logic       sticky_unf,
    output logic       sticky_inexact
);
    import fp16_pkg::*;

    fp_flags_t sticky_q;
    fp_flags_t new_flags;

    // collect the incoming flags, masked by valid so stale values never leak in
    always_comb begin
        new_flags         = '0;
        new_flags.ovf     = flags.valid & flags.ovf;
        new_flags.unf     = flags.valid & flags.unf;
        new_flags.inexact = flags.valid & flags.inexact;
    end

    // flags stay set until software clears them
    // a clear in the same cycle as a new flag wins, so that flag is dropped
    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            sticky_q <= '0;
        end else if (flags_clear) begin
            sticky_q <= '0;
        end else begin
            sticky_q <= sticky_q | new_flags;
        end
    end

    assign sticky_ovf     = sticky_q.ovf;
    assign sticky_unf     = sticky_q.unf;
    assign sticky_inexact = sticky_q.inexact;

    // any sticky bit that comes up must trace back to a result from the adder
    a_sticky_needs_valid: assert property (@(posedge clk) disable iff (!nRST)
        ($rose(sticky_ovf) || $rose(sticky_unf) || $rose(sticky_inexact))
            |-> $past(flags.valid));

endmodule

// ==== hw/left_shift.sv ====
module left_shift (
    input  logic [fp16_pkg::MANT_W-1:0] fraction,
    output logic [fp16_pkg::MANT_W-1:0] result,
    output logic [3:0]                  shifted_amount
);
    import fp16_pkg::*;

    logic found;

    // leading zero count by a priority scan from the top bit down
    // an all-zero input keeps the default count of MANT_W
    always_comb begin
        shifted_amount = 4'(MANT_W);
        found          = 1'b0;
        for (int i = MANT_W - 1; i >= 0; i--) begin
            if (!found && fraction[i]) begin
                shifted_amount = 4'(MANT_W - 1 - i);
                found          = 1'b1;
            end
        end
    end

    // shifting left by the count puts the first one into the hidden bit position
    // a full-width shift of a zero input still gives zero
    assign result = fraction << shifted_amount;

endmodule

// ==== testbench/tb_fp16_add_unit.sv ====
module tb_fp16_add_unit;
    timeunit 1ns;
    timeprecision 1ps;
    import fp16_pkg::*;

    localparam int RESET_CYCLES = 2;
    localparam int N_RANDOM     = 150;
    // upper bounds on the directed operations and idle gaps, each costs one cycle
    localparam int N_DIRECTED   = 40;
    localparam int N_IDLE       = 60;
    // a random operation takes one cycle plus at most one idle gap
    localparam int STIM_CYCLES    = RESET_CYCLES + 2 * N_RANDOM + N_DIRECTED + N_IDLE;
    localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES;

    localparam int T_SAME   = 0;
    localparam int T_RANDOM = 1;
    localparam int T_OPP    = 2;
    localparam int T_ROUND  = 3;
    localparam int T_OVF    = 4;
    localparam int T_ZERO   = 5;
    localparam int T_UNF    = 6;
    localparam int T_TIMING = 7;

    logic   clk = 1'b0;
    logic   nRST;
    logic   start;
    fp16_t  fp1_in;
    fp16_t  fp2_in;
    logic   flags_clear;
    fp16_t  fp_out;
    logic   output_ready;
    logic   ovf;
    logic   unf;
    logic   inexact;
    logic   sticky_ovf;
    logic   sticky_unf;
    logic   sticky_inexact;

    // expected values set up alongside the inputs, then moved one stage on like the DUT
    fp16_t      drv_out;
    logic [2:0] drv_flags;
    int         drv_test;
    logic       chk_valid;
    fp16_t      chk_out;
    logic [2:0] chk_flags;
    int         chk_test;
    logic [2:0] sticky_model;
    integer     seed = 67;
    int         cycle_count = 0;

    fp16_add_unit i_dut (
        .clk            (clk),
        .nRST           (nRST),
        .start          (start),
        .fp1_in         (fp1_in),
        .fp2_in         (fp2_in),
        .flags_clear    (flags_clear),
        .fp_out         (fp_out),
        .output_ready   (output_ready),
        .ovf            (ovf),
        .unf            (unf),
        .inexact        (inexact),
        .sticky_ovf     (sticky_ovf),
        .sticky_unf     (sticky_unf),
        .sticky_inexact (sticky_inexact)
    );

    always #2 clk = ~clk;

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    function automatic string test_name(input int id);
        case (id)
            T_SAME:   return "same_sign";
            T_RANDOM: return "random_int";
            T_OPP:    return "opposite_sign";
            T_ROUND:  return "rounding";
            T_OVF:    return "overflow";
            T_ZERO:   return "zero";
            T_UNF:    return "underflow";
            default:  return "timing";
        endcase
    endfunction

    // exact value of an FP16 word in units of 2^-24, the smallest normal ulp
    function automatic longint scaled_value(input fp16_t x);
        longint mag;
        mag = 0;
        if (x.exp != 0)
            mag = longint'({1'b1, x.frac}) << (x.exp - 1);
        return x.sign ? -mag : mag;
    endfunction

    // round an exact value to FP16 with ties to even and flush below the normal range
    // the result is {ovf, unf, inexact, word}
    function automatic logic [18:0] round_to_fp16(input longint s, input logic zero_sign);
        longint     mag;
        longint     mant;
        longint     rem;
        longint     half;
        int         p;
        int         e;
        int         shift;
        logic       sign;
        logic [2:0] fl;
        fp16_t      w;
        sign = (s < 0);
        mag  = sign ? -s : s;
        fl   = 3'b000;
        w    = '0;
        if (mag == 0) begin
            w.sign = zero_sign;
            return {fl, w};
        end
        p = 0;
        for (int i = 0; i < 48; i++) begin
            if ((mag >> i) != 0)
                p = i;
        end
        // the leading one sits at bit 10 of the significand for exponent 1
        e     = p - 9;
        shift = p - 10;
        if (shift > 0) begin
            mant = mag >> shift;
            rem  = mag - (mant << shift);
            half = longint'(1) << (shift - 1);
        end else begin
            mant = mag << (-shift);
            rem  = 0;
            half = 1;
        end
        fl[0]  = (rem != 0);
        w.sign = sign;
        if (e < 1) begin
            fl[1] = 1'b1;
            return {fl, w};
        end
        if (rem > half || (rem == half && (mant % 2) == 1))
            mant = mant + 1;
        if (mant == 2048) begin
            mant = 1024;
            e    = e + 1;
        end
        if (e > EXP_MAX) begin
            fl[2] = 1'b1;
            w.exp = '1;
            return {fl, w};
        end
        w.exp  = 5'(e);
        w.frac = 10'(mant);
        return {fl, w};
    endfunction

    function automatic logic [18:0] model_add(input fp16_t a, input fp16_t b);
        return round_to_fp16(scaled_value(a) + scaled_value(b), a.sign & b.sign);
    endfunction

    // present one operand pair with start for a single cycle
    task automatic drive_op(input int id, input fp16_t a, input fp16_t b);
        logic [18:0] m;
        m         = model_add(a, b);
        fp1_in    = a;
        fp2_in    = b;
        start     = 1'b1;
        drv_out   = m[15:0];
        drv_flags = m[18:16];
        drv_test  = id;
        @(negedge clk);
    endtask

    task automatic idle(input int n);
        start = 1'b0;
        repeat (n) @(negedge clk);
    endtask

    task automatic clear_flags();
        start       = 1'b0;
        flags_clear = 1'b1;
        @(negedge clk);
        flags_clear = 1'b0;
    endtask

    // the model pipeline mirrors the one cycle of latency and the sticky register
    always @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            chk_valid    <= 1'b0;
            chk_out      <= '0;
            chk_flags    <= '0;
            chk_test     <= 0;
            sticky_model <= '0;
        end else begin
            chk_valid <= start;
            if (start) begin
                chk_out   <= drv_out;
                chk_flags <= drv_flags;
                chk_test  <= drv_test;
            end
            if (flags_clear)
                sticky_model <= '0;
            else if (chk_valid)
                sticky_model <= sticky_model | chk_flags;
        end
    end

    a_ready: assert property (@(posedge clk) disable iff (!nRST) output_ready == chk_valid)
        else abort_run("output_ready does not follow start by exactly one cycle");

    a_result: assert property (@(posedge clk) disable iff (!nRST) chk_valid |-> fp_out == chk_out)
        else abort_run($sformatf("MISMATCH test=%s expected=%h actual=%h",
            test_name($sampled(chk_test)), $sampled(chk_out), $sampled(fp_out)));

    // per-result flags must be low whenever no result is presented
    a_flags: assert property (@(posedge clk) disable iff (!nRST)
        {ovf, unf, inexact} == (chk_valid ? chk_flags : 3'b000))
        else abort_run($sformatf("MISMATCH test=%s flags expected=%b actual=%b",
            test_name($sampled(chk_test)), $sampled(chk_valid ? chk_flags : 3'b000),
            $sampled({ovf, unf, inexact})));

    a_sticky: assert property (@(posedge clk) disable iff (!nRST)
        {sticky_ovf, sticky_unf, sticky_inexact} == sticky_model)
        else abort_run($sformatf("MISMATCH test=%s sticky expected=%b actual=%b",
            test_name($sampled(chk_test)), $sampled(sticky_model),
            $sampled({sticky_ovf, sticky_unf, sticky_inexact})));

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES)
            abort_run("timeout: the stimulus did not finish within the cycle limit");
    end

    initial begin
        integer      n1;
        integer      n2;
        logic [18:0] enc1;
        logic [18:0] enc2;
        nRST        = 1'b0;
        start       = 1'b0;
        fp1_in      = '0;
        fp2_in      = '0;
        flags_clear = 1'b0;
        drv_out     = '0;
        drv_flags   = '0;
        drv_test    = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        nRST = 1'b1;
        assert (fp_out == '0 && !output_ready && !ovf && !unf && !inexact &&
                !sticky_ovf && !sticky_unf && !sticky_inexact)
            else abort_run("outputs or flags are not cleared after reset");

        // exact same-sign sums, including a carry into a new binade
        drive_op(T_SAME, 16'h3C00, 16'h4000);
        drive_op(T_SAME, 16'h3E00, 16'h3E00);
        drive_op(T_SAME, 16'hC000, 16'hC200);
        drive_op(T_SAME, 16'h3800, 16'h3400);
        drive_op(T_SAME, 16'h6400, 16'h6400);
        idle(2);

        drive_op(T_OPP, 16'h4200, 16'hC500);
        drive_op(T_OPP, 16'hBC00, 16'h4400);
        drive_op(T_OPP, 16'h4500, 16'hC500);
        drive_op(T_OPP, 16'hBA00, 16'h3A00);
        drive_op(T_OPP, 16'h3C00, 16'hB800);
        idle(2);

        // a tie to even that stays, and a tie that rounds up from an odd lsb
        drive_op(T_ROUND, 16'h3C00, 16'h1000);
        drive_op(T_ROUND, 16'h3C00, 16'h1600);
        drive_op(T_ROUND, 16'hBC00, 16'h9000);
        // bits lost during alignment break the tie and force a round up
        drive_op(T_ROUND, 16'h3C00, 16'h1002);
        idle(2);

        drive_op(T_ZERO, 16'h0000, 16'h4248);
        drive_op(T_ZERO, 16'hC0A0, 16'h0000);
        drive_op(T_ZERO, 16'h8000, 16'h8000);
        drive_op(T_ZERO, 16'h0000, 16'h8000);
        idle(2);

        // the largest finite value doubled overflows and the sticky bit holds it
        drive_op(T_OVF, 16'h7BFF, 16'h7BFF);
        idle(1);
        assert (sticky_ovf) else abort_run("sticky overflow flag was not set");
        drive_op(T_OVF, 16'h3C00, 16'h3C00);
        idle(3);
        assert (sticky_ovf) else abort_run("sticky overflow flag did not hold until clear");
        clear_flags();
        assert (!sticky_ovf) else abort_run("sticky overflow flag did not fall after clear");
        // a clear in the same cycle as a new overflow wins
        drive_op(T_OVF, 16'hFBFF, 16'hFBFF);
        clear_flags();
        assert (!sticky_ovf) else abort_run("flags_clear lost against a new overflow");
        idle(1);

        // cancellation just below the smallest normal flushes to a signed zero
        drive_op(T_UNF, 16'h0600, 16'h8400);
        drive_op(T_UNF, 16'h8600, 16'h0400);
        idle(1);
        assert (sticky_unf) else abort_run("sticky underflow flag was not set");
        clear_flags();
        idle(1);

        // back-to-back starts give a result on every cycle
        drive_op(T_TIMING, 16'h3C00, 16'h3C00);
        drive_op(T_TIMING, 16'h4000, 16'h4000);
        drive_op(T_TIMING, 16'h4200, 16'hC000);
        drive_op(T_TIMING, 16'h7BFF, 16'h7800);
        idle(2);

        // integers up to 2048 in magnitude encode exactly and sometimes run back to back
        for (int i = 0; i < N_RANDOM; i++) begin
            n1   = $random(seed) % 2049;
            n2   = $random(seed) % 2049;
            enc1 = round_to_fp16(longint'(n1) <<< 24, 1'b0);
            enc2 = round_to_fp16(longint'(n2) <<< 24, 1'b0);
            drive_op(T_RANDOM, enc1[15:0], enc2[15:0]);
            if (($random(seed) % 2) != 0)
                idle(1);
        end
        idle(3);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== verilog.f ====
hw/fp16_pkg.sv
hw/fp_flags_if.sv
hw/left_shift.sv
hw/fp16_align.sv
hw/fp16_add_round.sv
hw/fp_status_reg.sv
hw/fp16_add_unit.sv
testbench/tb_fp16_add_unit.sv
